//--- Bender.yml
package:
  name: astar_open_sort

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/astar_pkg.sv
      - rtl/octile_cost.sv
      - rtl/open_list_loader.sv
      - rtl/open_list_ram.sv
      - rtl/bubble_sorter.sv
      - rtl/astar_open_sort_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_astar_open_sort.sv

//--- flist.f
+incdir+rtl
rtl/astar_pkg.sv
rtl/octile_cost.sv
rtl/open_list_loader.sv
rtl/open_list_ram.sv
rtl/bubble_sorter.sv
rtl/astar_open_sort_top.sv
tests/tb_astar_open_sort.sv

//--- rtl/astar_defs.svh
`ifndef ASTAR_DEFS_SVH
`define ASTAR_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// widths and list size
////////////////////////////////////////////////////////////////////////////

`define COORD_W     8     // one grid coordinate
`define COST_W      10    // goal part plus start part up to 720
`define OPEN_DEPTH  16    // open list entries
`define IDX_W       4     // entry index
`define COUNT_W     5     // fill count of 0 to 16

////////////////////////////////////////////////////////////////////////////
// diagonal factor (sqrt2 - 1) in fixed point
////////////////////////////////////////////////////////////////////////////

`define DIAG_NUM    106
`define DIAG_SHIFT  8     // 106/256 ~ 0.414

`endif

//--- rtl/astar_open_sort_top.sv
`timescale 1ns/1ps
`include "astar_defs.svh"

module astar_open_sort_top import astar_pkg::*; (
	input  logic                Clk,
	input  logic                Reset,
	input  logic                node_valid,
	output logic                node_ready,
	input  logic [`COORD_W-1:0] node_x,
	input  logic [`COORD_W-1:0] node_y,
	input  logic [`COORD_W-1:0] start_x,
	input  logic [`COORD_W-1:0] start_y,
	input  logic [`COORD_W-1:0] goal_x,
	input  logic [`COORD_W-1:0] goal_y,
	input  logic                sort_start,
	output logic                out_valid,
	input  logic                out_ready,
	output logic [`COORD_W-1:0] out_x,
	output logic [`COORD_W-1:0] out_y,
	output logic [`COST_W-1:0]  out_cost,
	output logic                out_last,
	output logic                busy
);

	logic [`COUNT_W-1:0] count;
	logic                list_clear;
	logic                wr_en;
	logic [`IDX_W-1:0]   wr_idx;
	node_word_u          wr_word;
	logic [`COST_W-1:0]  wr_cost;
	logic [`IDX_W-1:0]   rd_idx;
	node_word_u          rd_word_a;
	logic [`COST_W-1:0]  rd_cost_a;
	logic [`COST_W-1:0]  rd_cost_b;
	logic                swap;
	logic [`IDX_W-1:0]   swap_idx;

	open_list_loader i_loader (
		.Clk        (Clk),
		.Reset      (Reset),
		.node_valid (node_valid),
		.node_ready (node_ready),
		.node_x     (node_x),
		.node_y     (node_y),
		.start_x    (start_x),
		.start_y    (start_y),
		.goal_x     (goal_x),
		.goal_y     (goal_y),
		.busy       (busy),
		.list_clear (list_clear),
		.count      (count),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_word    (wr_word),
		.wr_cost    (wr_cost)
	);

	open_list_ram i_ram (
		.Clk       (Clk),
		.Reset     (Reset),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_word   (wr_word),
		.wr_cost   (wr_cost),
		.swap      (swap),
		.swap_idx  (swap_idx),
		.rd_idx    (rd_idx),
		.rd_word_a (rd_word_a),
		.rd_cost_a (rd_cost_a),
		.rd_word_b (),             // sorter only compares costs of b
		.rd_cost_b (rd_cost_b)
	);

	bubble_sorter i_sorter (
		.Clk        (Clk),
		.Reset      (Reset),
		.sort_start (sort_start),
		.count      (count),
		.busy       (busy),
		.rd_idx     (rd_idx),
		.rd_word_a  (rd_word_a),
		.rd_cost_a  (rd_cost_a),
		.rd_cost_b  (rd_cost_b),
		.swap       (swap),
		.swap_idx   (swap_idx),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_x      (out_x),
		.out_y      (out_y),
		.out_cost   (out_cost),
		.out_last   (out_last),
		.list_clear (list_clear)
	);

endmodule

//--- rtl/astar_pkg.sv
`include "astar_defs.svh"

package astar_pkg;

	// one open list entry
	// the list memory sees a flat word and the datapath sees x and y
	typedef union packed
	{
		logic [2*`COORD_W-1:0] raw;
		struct packed
		{
			logic [`COORD_W-1:0] x;   // high byte
			logic [`COORD_W-1:0] y;   // low byte
		} coord;
	} node_word_u;

endpackage

//--- rtl/bubble_sorter.sv
`timescale 1ns/1ps
`include "astar_defs.svh"

module bubble_sorter import astar_pkg::*; (
	input  logic                Clk,
	input  logic                Reset,
	input  logic                sort_start,
	input  logic [`COUNT_W-1:0] count,
	output logic                busy,
	output logic [`IDX_W-1:0]   rd_idx,
	input  node_word_u          rd_word_a,
	input  logic [`COST_W-1:0]  rd_cost_a,
	input  logic [`COST_W-1:0]  rd_cost_b,
	output logic                swap,
	output logic [`IDX_W-1:0]   swap_idx,
	output logic                out_valid,
	input  logic                out_ready,
	output logic [`COORD_W-1:0] out_x,
	output logic [`COORD_W-1:0] out_y,
	output logic [`COST_W-1:0]  out_cost,
	output logic                out_last,
	output logic                list_clear
);

	localparam logic [1:0] IDLE     = 2'd0;
	localparam logic [1:0] COMPARE  = 2'd1;
	localparam logic [1:0] PASS_END = 2'd2;
	localparam logic [1:0] EMIT     = 2'd3;

	logic [1:0]          state;
	logic [`IDX_W-1:0]   idx;
	logic                swapped;    // any swap in this pass
	logic [`COUNT_W-1:0] idx_next;
	logic                start_go;
	logic                pair_ok;
	logic                pair_last;
	logic                out_fire;

	assign idx_next  = {1'b0, idx} + 1'b1;
	assign pair_ok   = idx_next < count;            // entry i+1 is loaded
	assign pair_last = idx_next >= count - 1'b1;    // also ends a one-entry pass
	assign start_go  = sort_start && (state == IDLE) && (count != '0);
	assign busy      = (state != IDLE) || start_go; // blocks a load in the start cycle

	////////////////////////////////////////////////////////////////////////////
	// compare/swap and output datapath
	////////////////////////////////////////////////////////////////////////////

	assign rd_idx   = idx;
	assign swap_idx = idx;
	// strict compare keeps equal costs in load order
	assign swap     = (state == COMPARE) && pair_ok && (rd_cost_a > rd_cost_b);

	assign out_valid  = (state == EMIT);
	assign out_x      = rd_word_a.coord.x;
	assign out_y      = rd_word_a.coord.y;
	assign out_cost   = rd_cost_a;
	assign out_last   = out_valid && (idx_next == count);
	assign out_fire   = out_valid && out_ready;
	assign list_clear = out_fire && out_last;      // count drops with the final handshake

	////////////////////////////////////////////////////////////////////////////
	// pass control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state   <= IDLE;
			idx     <= '0;
			swapped <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start_go)
					begin
						state   <= COMPARE;
						idx     <= '0;
						swapped <= 1'b0;
					end
				end
				COMPARE:
				begin
					if (swap)
						swapped <= 1'b1;
					if (pair_last)
						state <= PASS_END;
					else
						idx <= idx + 1'b1;
				end
				PASS_END:
				begin
					idx <= '0;
					if (swapped)
					begin
						swapped <= 1'b0;   // another pass
						state   <= COMPARE;
					end
					else
						state <= EMIT;     // list is in order
				end
				default:
				begin
					if (out_fire)
					begin
						if (out_last)
							state <= IDLE;
						else
							idx <= idx + 1'b1;
					end
				end
			endcase
		end
	end

	a_out_hold: assert property (@(posedge Clk) disable iff (Reset)
		out_valid && !out_ready |=> out_valid && $stable(out_x) && $stable(out_y)
			&& $stable(out_cost) && $stable(out_last));

endmodule

//--- rtl/octile_cost.sv
`timescale 1ns/1ps
`include "astar_defs.svh"

module octile_cost (
	input  logic                Clk,
	input  logic                Reset,
	input  logic                in,
	input  logic [`COORD_W-1:0] x,
	input  logic [`COORD_W-1:0] y,
	input  logic [`COORD_W-1:0] start_x,
	input  logic [`COORD_W-1:0] start_y,
	input  logic [`COORD_W-1:0] goal_x,
	input  logic [`COORD_W-1:0] goal_y,
	output logic [`COST_W-1:0]  cost,
	output logic                cost_valid
);

	logic [`COST_W-1:0] to_goal;
	logic [`COST_W-1:0] to_start;

	// max(dx,dy) + min(dx,dy)*106/256
	function automatic logic [`COST_W-1:0] octile(
		input logic [`COORD_W-1:0] ax,
		input logic [`COORD_W-1:0] ay,
		input logic [`COORD_W-1:0] bx,
		input logic [`COORD_W-1:0] by
	);
		logic [`COORD_W-1:0]             dx;
		logic [`COORD_W-1:0]             dy;
		logic [`COORD_W-1:0]             d_hi;
		logic [`COORD_W-1:0]             d_lo;
		logic [`COORD_W+`DIAG_SHIFT-1:0] diag;
		dx   = (ax > bx) ? ax - bx : bx - ax;
		dy   = (ay > by) ? ay - by : by - ay;
		d_hi = (dx > dy) ? dx : dy;
		d_lo = (dx > dy) ? dy : dx;
		diag = d_lo * `DIAG_NUM;   // 255*106 fits 16 bits
		return `COST_W'(d_hi) + `COST_W'(diag >> `DIAG_SHIFT);
	endfunction

	assign to_goal  = octile(x, y, goal_x, goal_y);
	assign to_start = octile(x, y, start_x, start_y);

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			cost_valid <= 1'b0;
		else
			cost_valid <= in;
	end

	always_ff @(posedge Clk)
	begin
		if (in)
			cost <= to_goal + to_start;   // each part <= 360
	end

endmodule

//--- rtl/open_list_loader.sv
`timescale 1ns/1ps
`include "astar_defs.svh"

module open_list_loader import astar_pkg::*; (
	input  logic                Clk,
	input  logic                Reset,
	input  logic                node_valid,
	output logic                node_ready,
	input  logic [`COORD_W-1:0] node_x,
	input  logic [`COORD_W-1:0] node_y,
	input  logic [`COORD_W-1:0] start_x,
	input  logic [`COORD_W-1:0] start_y,
	input  logic [`COORD_W-1:0] goal_x,
	input  logic [`COORD_W-1:0] goal_y,
	input  logic                busy,
	input  logic                list_clear,
	output logic [`COUNT_W-1:0] count,
	output logic                wr_en,
	output logic [`IDX_W-1:0]   wr_idx,
	output node_word_u          wr_word,
	output logic [`COST_W-1:0]  wr_cost
);

	logic                accept;
	logic                cost_valid;
	logic [`COST_W-1:0]  cost;
	logic [`COUNT_W-1:0] fill;
	node_word_u          pend_word;

	assign fill       = count + `COUNT_W'(cost_valid);   // written plus in flight
	assign node_ready = !busy && (fill < `OPEN_DEPTH);
	assign accept     = node_valid && node_ready;

	octile_cost i_cost (
		.Clk        (Clk),
		.Reset      (Reset),
		.in         (accept),
		.x          (node_x),
		.y          (node_y),
		.start_x    (start_x),
		.start_y    (start_y),
		.goal_x     (goal_x),
		.goal_y     (goal_y),
		.cost       (cost),
		.cost_valid (cost_valid)
	);

	always_ff @(posedge Clk)
	begin
		if (accept)
		begin
			pend_word.coord.x <= node_x;   // waits one cycle for its cost
			pend_word.coord.y <= node_y;
		end
	end

	// writes land in load order, so the next slot is the count
	assign wr_en   = cost_valid;
	assign wr_idx  = count[`IDX_W-1:0];
	assign wr_word = pend_word;
	assign wr_cost = cost;

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			count <= '0;
		else if (list_clear)
			count <= '0;
		else if (wr_en)
			count <= count + 1'b1;
	end

	a_no_write_full: assert property (@(posedge Clk) disable iff (Reset)
		wr_en |-> (count != `OPEN_DEPTH));

endmodule

//--- rtl/open_list_ram.sv
`timescale 1ns/1ps
`include "astar_defs.svh"

module open_list_ram import astar_pkg::*; (
	input  logic               Clk,
	input  logic               Reset,
	input  logic               wr_en,
	input  logic [`IDX_W-1:0]  wr_idx,
	input  node_word_u         wr_word,
	input  logic [`COST_W-1:0] wr_cost,
	input  logic               swap,
	input  logic [`IDX_W-1:0]  swap_idx,
	input  logic [`IDX_W-1:0]  rd_idx,
	output node_word_u         rd_word_a,
	output logic [`COST_W-1:0] rd_cost_a,
	output node_word_u         rd_word_b,
	output logic [`COST_W-1:0] rd_cost_b
);

	logic [2*`COORD_W-1:0] word_mem [`OPEN_DEPTH];
	logic [`COST_W-1:0]    cost_mem [`OPEN_DEPTH];
	logic [`IDX_W-1:0]     rd_idx_b;
	logic [`IDX_W-1:0]     swap_idx_b;

	assign rd_idx_b   = rd_idx + 1'b1;
	assign swap_idx_b = swap_idx + 1'b1;

	// neighbour pair read without a clock
	assign rd_word_a.raw = word_mem[rd_idx];
	assign rd_cost_a     = cost_mem[rd_idx];
	assign rd_word_b.raw = word_mem[rd_idx_b];
	assign rd_cost_b     = cost_mem[rd_idx_b];

	always_ff @(posedge Clk)
	begin
		if (wr_en)
		begin
			word_mem[wr_idx] <= wr_word.raw;
			cost_mem[wr_idx] <= wr_cost;
		end
		else if (swap)
		begin
			word_mem[swap_idx]   <= word_mem[swap_idx_b];   // exchange word and cost together
			word_mem[swap_idx_b] <= word_mem[swap_idx];
			cost_mem[swap_idx]   <= cost_mem[swap_idx_b];
			cost_mem[swap_idx_b] <= cost_mem[swap_idx];
		end
	end

	// loading and sorting never overlap
	a_no_wr_swap: assert property (@(posedge Clk) disable iff (Reset)
		!(wr_en && swap));

endmodule

//--- tests/tb_astar_open_sort.sv
`timescale 1ns/1ps
`include "astar_defs.svh"

module tb_astar_open_sort;

	localparam int LOAD_TIMEOUT = 32;
	localparam int SORT_TIMEOUT = `OPEN_DEPTH * (`OPEN_DEPTH + 1) + 16;
	localparam int BEAT_TIMEOUT = 64;

	logic                Clk;
	logic                Reset;
	logic                node_valid;
	logic                node_ready;
	logic [`COORD_W-1:0] node_x;
	logic [`COORD_W-1:0] node_y;
	logic [`COORD_W-1:0] start_x;
	logic [`COORD_W-1:0] start_y;
	logic [`COORD_W-1:0] goal_x;
	logic [`COORD_W-1:0] goal_y;
	logic                sort_start;
	logic                busy;
	logic                out_valid;
	logic                out_ready;
	logic                out_last;
	logic [`COORD_W-1:0] out_x;
	logic [`COORD_W-1:0] out_y;
	logic [`COST_W-1:0]  out_cost;

	logic [31:0]         lfsr;
	logic [`COORD_W-1:0] load_x [`OPEN_DEPTH];
	logic [`COORD_W-1:0] load_y [`OPEN_DEPTH];
	logic [`COORD_W-1:0] exp_x [`OPEN_DEPTH];
	logic [`COORD_W-1:0] exp_y [`OPEN_DEPTH];
	int                  exp_cost [`OPEN_DEPTH];
	int                  loaded;      // handshakes since the last list_clear
	int                  exp_n;
	int                  out_idx;     // index of the beat on the out stream
	int                  last_cost;
	int                  beats_total;

	astar_open_sort_top i_dut (
		.Clk        (Clk),
		.Reset      (Reset),
		.node_valid (node_valid),
		.node_ready (node_ready),
		.node_x     (node_x),
		.node_y     (node_y),
		.start_x    (start_x),
		.start_y    (start_y),
		.goal_x     (goal_x),
		.goal_y     (goal_y),
		.sort_start (sort_start),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_x      (out_x),
		.out_y      (out_y),
		.out_cost   (out_cost),
		.out_last   (out_last),
		.busy       (busy)
	);

	initial
	begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// larger axis step plus 106/256 of the smaller one
	function automatic int axis_cost(input int a_x, input int a_y, input int b_x, input int b_y);
		int dx;
		int dy;
		dx = (a_x > b_x) ? a_x - b_x : b_x - a_x;
		dy = (a_y > b_y) ? a_y - b_y : b_y - a_y;
		if (dx > dy)
			return dx + (dy * 106) / 256;
		return dy + (dx * 106) / 256;
	endfunction

	function automatic int total_cost(input int x, input int y, input int sx, input int sy,
		input int gx, input int gy);
		return axis_cost(x, y, gx, gy) + axis_cost(x, y, sx, sy);
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		begin
			v = '0;
			for (int i = 0; i < n; i++)
			begin
				lfsr = lfsr_step(lfsr);
				v    = {v[30:0], lfsr[0]};
			end
		end
	endtask

	task automatic fail_run(input string line);
		begin
			$display("%s", line);
			$display(">>> FAIL");
			$fatal(1, "simulation stopped");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_reset_state: assert property (@(posedge Clk)
		$fell(Reset) |-> node_ready && !out_valid && !busy && (i_dut.count == '0))
		else fail_run($sformatf("Error at %0t: engine not idle and empty after reset", $time));

	a_full_stalls: assert property (@(posedge Clk) disable iff (Reset)
		(loaded == `OPEN_DEPTH) |-> !node_ready)
		else fail_run($sformatf("Error at %0t: node_ready high with a full list", $time));

	a_busy_stalls: assert property (@(posedge Clk) disable iff (Reset)
		busy |-> !node_ready)
		else fail_run($sformatf("Error at %0t: node_ready high while busy", $time));

	// busy holds from an accepted start to the final beat
	a_busy_span: assert property (@(posedge Clk) disable iff (Reset)
		(sort_start || busy) && !(out_valid && out_ready && out_last) |=> busy)
		else fail_run($sformatf("Error at %0t: busy low during a sort", $time));

	a_cost_rule: assert property (@(posedge Clk) disable iff (Reset)
		out_valid && out_ready |->
			out_cost == total_cost(out_x, out_y, start_x, start_y, goal_x, goal_y))
		else fail_run($sformatf("Error at %0t: out_cost %0d for node (%0d,%0d), expected %0d",
			$time, $sampled(out_cost), $sampled(out_x), $sampled(out_y),
			total_cost($sampled(out_x), $sampled(out_y), start_x, start_y, goal_x, goal_y)));

	a_ascending: assert property (@(posedge Clk) disable iff (Reset)
		out_valid && out_ready |-> out_cost >= last_cost)
		else fail_run($sformatf("Error at %0t: out_cost %0d below previous %0d",
			$time, $sampled(out_cost), last_cost));

	a_stable_order: assert property (@(posedge Clk) disable iff (Reset)
		out_valid && out_ready |-> out_x == exp_x[out_idx] && out_y == exp_y[out_idx])
		else fail_run($sformatf("Error at %0t: beat %0d is (%0d,%0d), expected (%0d,%0d)",
			$time, out_idx, $sampled(out_x), $sampled(out_y), exp_x[out_idx], exp_y[out_idx]));

	a_last_flag: assert property (@(posedge Clk) disable iff (Reset)
		out_valid && out_ready |-> out_last == (out_idx == exp_n - 1))
		else fail_run($sformatf("Error at %0t: out_last %0b on beat %0d of %0d",
			$time, $sampled(out_last), out_idx, exp_n));

	a_out_hold: assert property (@(posedge Clk) disable iff (Reset)
		out_valid && !out_ready |=> out_valid && $stable(out_x) && $stable(out_y)
			&& $stable(out_cost) && $stable(out_last))
		else fail_run($sformatf("Error at %0t: out stream changed under back-pressure", $time));

	a_restart_ignored: assert property (@(posedge Clk) disable iff (Reset)
		sort_start && out_valid |=> out_valid)
		else fail_run($sformatf("Error at %0t: sort_start while busy broke the stream", $time));

	// final beat clears the list and frees the loader
	a_batch_done: assert property (@(posedge Clk) disable iff (Reset)
		out_valid && out_ready && out_last |=> !busy && !out_valid && node_ready)
		else fail_run($sformatf("Error at %0t: engine not idle after the last beat", $time));

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic load_node(input logic [`COORD_W-1:0] x, input logic [`COORD_W-1:0] y);
		int waited;
		begin
			node_x     = x;
			node_y     = y;
			node_valid = 1'b1;
			waited     = 0;
			@(negedge Clk);
			while (!node_ready && waited < LOAD_TIMEOUT)
			begin
				waited++;
				@(negedge Clk);
			end
			if (!node_ready)
				fail_run("load stream stuck, node_ready never came back");
			@(posedge Clk);
			#1;
			load_x[loaded] = x;
			load_y[loaded] = y;
			loaded++;
			node_valid = 1'b0;
		end
	endtask

	task automatic load_random(input int n);
		logic [31:0] rx;
		logic [31:0] ry;
		begin
			for (int i = 0; i < n; i++)
			begin
				take_bits(`COORD_W, rx);
				take_bits(`COORD_W, ry);
				load_node(rx[`COORD_W-1:0], ry[`COORD_W-1:0]);
			end
		end
	endtask

	// insertion sort keeps ties in load order
	task automatic prepare_expected();
		logic [`COORD_W-1:0] kx;
		logic [`COORD_W-1:0] ky;
		int                  kc;
		int                  j;
		begin
			exp_n = loaded;
			for (int i = 0; i < exp_n; i++)
			begin
				kx = load_x[i];
				ky = load_y[i];
				kc = total_cost(kx, ky, start_x, start_y, goal_x, goal_y);
				j  = i;
				while (j > 0 && exp_cost[j-1] > kc)
				begin
					exp_x[j]    = exp_x[j-1];
					exp_y[j]    = exp_y[j-1];
					exp_cost[j] = exp_cost[j-1];
					j--;
				end
				exp_x[j]    = kx;
				exp_y[j]    = ky;
				exp_cost[j] = kc;
			end
		end
	endtask

	task automatic pulse_sort();
		begin
			repeat (2) @(posedge Clk);   // last cost write lands first
			#1;
			sort_start = 1'b1;
			@(posedge Clk);
			#1;
			sort_start = 1'b0;
		end
	endtask

	task automatic drain_output(input bit poke);
		int          waited;
		logic [31:0] r;
		bit          poked;
		bit          fire;
		begin
			out_idx   = 0;
			last_cost = 0;
			poked     = 1'b0;
			fire      = 1'b0;
			waited    = 0;
			@(negedge Clk);
			while (!out_valid && waited < SORT_TIMEOUT)
			begin
				waited++;
				@(negedge Clk);
			end
			if (!out_valid)
				fail_run("sort never finished, out_valid stayed low");
			waited = 0;
			while (out_idx < exp_n)
			begin
				@(posedge Clk);
				#1;
				sort_start = 1'b0;
				if (fire)
				begin
					last_cost = exp_cost[out_idx];
					out_idx++;
					beats_total++;
					waited = 0;
				end
				else
					waited++;
				if (waited > BEAT_TIMEOUT)
					fail_run("out stream stalled, no handshake in time");
				if (out_idx < exp_n)
				begin
					take_bits(2, r);
					out_ready = |r[1:0];   // one beat in four stalls
					if (poke && !poked && out_idx == 1)
					begin
						sort_start = 1'b1;
						poked      = 1'b1;
					end
				end
				else
					out_ready = 1'b0;
				@(negedge Clk);
				fire = out_valid && out_ready;
			end
			loaded = 0;
			@(posedge Clk);
			#1;
		end
	endtask

	initial
	begin
		logic [31:0] r;
		Reset       = 1'b1;
		node_valid  = 1'b0;
		node_x      = '0;
		node_y      = '0;
		start_x     = '0;
		start_y     = '0;
		goal_x      = '0;
		goal_y      = '0;
		sort_start  = 1'b0;
		out_ready   = 1'b0;
		lfsr        = 32'h6e79;
		loaded      = 0;
		exp_n       = 0;
		out_idx     = 0;
		last_cost   = 0;
		beats_total = 0;
		repeat (2) @(posedge Clk);
		#1;
		Reset = 1'b0;
		repeat (2) @(posedge Clk);
		#1;

		// full batch with random start and goal
		take_bits(32, r);
		{start_x, start_y, goal_x, goal_y} = r;
		load_random(`OPEN_DEPTH);
		node_x     = 8'h55;   // one more node offered to a full list
		node_y     = 8'haa;
		node_valid = 1'b1;
		repeat (3) @(posedge Clk);
		#1;
		node_valid = 1'b0;
		prepare_expected();
		pulse_sort();
		drain_output(1'b0);

		// mirror pair shares its cost
		start_x = 8'd10;
		start_y = 8'd10;
		goal_x  = 8'd40;
		goal_y  = 8'd40;
		load_node(8'd7, 8'd3);
		load_node(8'd3, 8'd7);
		load_node(8'd20, 8'd20);
		prepare_expected();
		pulse_sort();
		drain_output(1'b1);

		// second batch after list_clear
		take_bits(32, r);
		{start_x, start_y, goal_x, goal_y} = r;
		load_random(7);
		prepare_expected();
		pulse_sort();
		drain_output(1'b0);

		repeat (2) @(posedge Clk);
		if (beats_total == `OPEN_DEPTH + 3 + 7)
		begin
			$display(">>> PASS");
			$finish;
		end
		else
			fail_run($sformatf("wrong number of output beats, got %0d", beats_total));
	end

endmodule
